//--- rab_defs.svh
// width, slice count and config register layout macros for the remapping lane
`ifndef RAB_DEFS_SVH
`define RAB_DEFS_SVH

// address widths on the virtual and physical side
`define RAB_VADDR_W 32
`define RAB_PADDR_W 40

// config port data width
`define RAB_CFG_DATA_W 64

// slice bank layout with start, end, offset and flags per slice
`define RAB_N_SLICES 4
`define RAB_REGS_PER_SLICE 4
`define RAB_CFG_IDX_W 4

// burst fields of a request channel
`define RAB_SIZE_W 3
`define RAB_LEN_W 8

`endif

//--- rab_cfg_pkg.sv
// slice configuration types: register field enum and slice flag struct
package rab_cfg_pkg;

  // register within one slice, lower two bits of the config index
  typedef enum logic [1:0] {
    FIELD_START  = 2'd0,
    FIELD_END    = 2'd1,
    FIELD_OFFSET = 2'd2,
    FIELD_FLAGS  = 2'd3
  } cfg_field_e;

  // low four bits of a FLAGS register
  // enable sits in bit 0 and coherent in bit 3
  typedef struct packed {
    logic coherent;
    logic write_en;
    logic read_en;
    logic enable;
  } slice_flags_t;

endpackage

//--- rab_lookup_pkg.sv
// lookup types: FSM state enum and decision enum
package rab_lookup_pkg;

  // lookup FSM states
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_DECIDE    = 2'd1,
    ST_WAIT_SENT = 2'd2
  } lookup_state_e;

  // outcome of the slice compare for one request
  typedef enum logic [1:0] {
    DEC_ACCEPT = 2'd0,
    DEC_MISS   = 2'd1,
    DEC_PROT   = 2'd2,
    DEC_MULTI  = 2'd3
  } decision_e;

endpackage

//--- rab_cfg_regs.sv
// rab_cfg_regs: slice start, end, offset and flag registers behind the config write port
`timescale 1ns/1ps
`include "rab_defs.svh"

module rab_cfg_regs (
  input  logic                                                  Clk_CI,
  input  logic                                                  Rst_RBI,
  input  logic                                                  cfg_we_i,
  input  logic [`RAB_CFG_IDX_W-1:0]                             cfg_idx_i,
  input  logic [`RAB_CFG_DATA_W-1:0]                            cfg_data_i,
  output logic [`RAB_N_SLICES-1:0][`RAB_VADDR_W-1:0]            slice_start_o,
  output logic [`RAB_N_SLICES-1:0][`RAB_VADDR_W-1:0]            slice_end_o,
  output logic [`RAB_N_SLICES-1:0][`RAB_PADDR_W-1:0]            slice_offset_o,
  output rab_cfg_pkg::slice_flags_t [`RAB_N_SLICES-1:0]         slice_flags_o
);

  localparam int VADDR_W = `RAB_VADDR_W;
  localparam int PADDR_W = `RAB_PADDR_W;
  localparam int SLICE_W = $clog2(`RAB_N_SLICES);
  localparam int FLAGS_W = $bits(rab_cfg_pkg::slice_flags_t);

  logic [SLICE_W-1:0]      slice_sel;
  rab_cfg_pkg::cfg_field_e field_sel;

  // index = slice * regs per slice + field
  assign slice_sel = SLICE_W'(cfg_idx_i / `RAB_REGS_PER_SLICE);
  assign field_sel = rab_cfg_pkg::cfg_field_e'(2'(cfg_idx_i % `RAB_REGS_PER_SLICE));

  // every slice comes out of reset disabled
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      slice_start_o  <= '0;
      slice_end_o    <= '0;
      slice_offset_o <= '0;
      slice_flags_o  <= '0;
    end else if (cfg_we_i) begin
      case (field_sel)
        rab_cfg_pkg::FIELD_START: begin
          slice_start_o[slice_sel] <= cfg_data_i[VADDR_W-1:0];
        end
        rab_cfg_pkg::FIELD_END: begin
          slice_end_o[slice_sel] <= cfg_data_i[VADDR_W-1:0];
        end
        rab_cfg_pkg::FIELD_OFFSET: begin
          slice_offset_o[slice_sel] <= cfg_data_i[PADDR_W-1:0];
        end
        rab_cfg_pkg::FIELD_FLAGS: begin
          slice_flags_o[slice_sel] <= rab_cfg_pkg::slice_flags_t'(cfg_data_i[FLAGS_W-1:0]);
        end
      endcase
    end
  end

endmodule

//--- rab_req_arbiter.sv
// rab_req_arbiter: channel priority, burst end address and request multiplexing
`timescale 1ns/1ps
`include "rab_defs.svh"

module rab_req_arbiter (
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  input  logic [`RAB_VADDR_W-1:0] p1_addr_i,
  input  logic [`RAB_VADDR_W-1:0] p2_addr_i,
  input  logic [`RAB_LEN_W-1:0]   p1_len_i,
  input  logic [`RAB_LEN_W-1:0]   p2_len_i,
  input  logic [`RAB_SIZE_W-1:0]  p1_size_i,
  input  logic [`RAB_SIZE_W-1:0]  p2_size_i,
  input  logic                    p1_valid_i,
  input  logic                    p2_valid_i,
  input  logic                    grant_p1_i,
  input  logic                    grant_p2_i,
  output logic [`RAB_VADDR_W-1:0] sel_addr_min_o,
  output logic [`RAB_VADDR_W-1:0] sel_addr_max_o,
  output logic                    sel_is_write_o,
  output logic                    sel_port_o,
  output logic                    any_valid_o
);

  localparam int VADDR_W = `RAB_VADDR_W;
  localparam int LEN_W   = `RAB_LEN_W;
  localparam int SIZE_W  = `RAB_SIZE_W;

  logic               prio_p1_q;
  logic               sel_p1;
  logic [VADDR_W-1:0] p1_end;
  logic [VADDR_W-1:0] p2_end;

  // last byte of a burst
  // the start is aligned down to the beat within the 8-byte bus word first
  function automatic logic [VADDR_W-1:0] burst_end(
    input logic [VADDR_W-1:0] addr,
    input logic [LEN_W-1:0]   len,
    input logic [SIZE_W-1:0]  size
  );
    logic [2:0]         low_mask;
    logic [VADDR_W-1:0] aligned;
    logic [VADDR_W-1:0] n_bytes;
    low_mask = 3'b111 << size;
    aligned  = {addr[VADDR_W-1:3], addr[2:0] & low_mask};
    n_bytes  = (VADDR_W'(len) + VADDR_W'(1)) << size;
    return aligned + n_bytes - VADDR_W'(1);
  endfunction

  // priority flips to the other channel after each grant
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      prio_p1_q <= 1'b1;
    end else if (grant_p1_i) begin
      prio_p1_q <= 1'b0;
    end else if (grant_p2_i) begin
      prio_p1_q <= 1'b1;
    end
  end

  assign sel_p1 = p1_valid_i & (prio_p1_q | ~p2_valid_i);

  assign p1_end = burst_end(p1_addr_i, p1_len_i, p1_size_i);
  assign p2_end = burst_end(p2_addr_i, p2_len_i, p2_size_i);

  // channel 2 carries the writes
  assign sel_addr_min_o = sel_p1 ? p1_addr_i : p2_addr_i;
  assign sel_addr_max_o = sel_p1 ? p1_end : p2_end;
  assign sel_is_write_o = ~sel_p1;
  // high selects channel 1
  assign sel_port_o     = sel_p1;
  assign any_valid_o    = p1_valid_i | p2_valid_i;

endmodule

//--- rab_slice_match.sv
// rab_slice_match: range compare over all slices with hit, protection and address translation
`timescale 1ns/1ps
`include "rab_defs.svh"

module rab_slice_match (
  input  logic [`RAB_VADDR_W-1:0]                       sel_addr_min_i,
  input  logic [`RAB_VADDR_W-1:0]                       sel_addr_max_i,
  input  logic                                          sel_is_write_i,
  input  logic [`RAB_N_SLICES-1:0][`RAB_VADDR_W-1:0]    slice_start_i,
  input  logic [`RAB_N_SLICES-1:0][`RAB_VADDR_W-1:0]    slice_end_i,
  input  logic [`RAB_N_SLICES-1:0][`RAB_PADDR_W-1:0]    slice_offset_i,
  input  rab_cfg_pkg::slice_flags_t [`RAB_N_SLICES-1:0] slice_flags_i,
  output rab_lookup_pkg::decision_e                     decision_o,
  output logic [`RAB_PADDR_W-1:0]                       out_addr_o,
  output logic                                          coherent_o
);

  localparam int N_SLICES = `RAB_N_SLICES;
  localparam int PADDR_W  = `RAB_PADDR_W;
  localparam int IDX_W    = $clog2(N_SLICES);
  localparam int CNT_W    = $clog2(N_SLICES) + 1;

  logic [N_SLICES-1:0]       hit;
  logic [CNT_W-1:0]          n_hits;
  logic [IDX_W-1:0]          hit_idx;
  rab_cfg_pkg::slice_flags_t hit_flags;
  logic                      rw_ok;

  // the whole burst range must fall inside an enabled slice
  always_comb begin
    n_hits  = '0;
    hit_idx = '0;
    for (int i = 0; i < N_SLICES; i++) begin
      hit[i] = slice_flags_i[i].enable &&
               (slice_start_i[i] <= sel_addr_min_i) &&
               (sel_addr_max_i <= slice_end_i[i]);
      if (hit[i]) begin
        n_hits  = n_hits + 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  assign hit_flags = slice_flags_i[hit_idx];
  assign rw_ok     = sel_is_write_i ? hit_flags.write_en : hit_flags.read_en;

  // physical address = virtual - slice start + slice offset
  assign out_addr_o = PADDR_W'(sel_addr_min_i) - PADDR_W'(slice_start_i[hit_idx]) +
                      slice_offset_i[hit_idx];
  assign coherent_o = hit_flags.coherent;

  // multi-hit wins over protection
  always_comb begin
    if (n_hits == '0) begin
      decision_o = rab_lookup_pkg::DEC_MISS;
    end else if (n_hits > CNT_W'(1)) begin
      decision_o = rab_lookup_pkg::DEC_MULTI;
    end else if (!rw_ok) begin
      decision_o = rab_lookup_pkg::DEC_PROT;
    end else begin
      decision_o = rab_lookup_pkg::DEC_ACCEPT;
    end
  end

endmodule

//--- rab_lookup_fsm.sv
// rab_lookup_fsm: capture, decide and wait-for-sent FSM with registered address outputs
`timescale 1ns/1ps
`include "rab_defs.svh"

module rab_lookup_fsm (
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  logic                      any_valid_i,
  input  logic                      sel_port_i,
  input  logic [`RAB_VADDR_W-1:0]   sel_addr_min_i,
  input  rab_lookup_pkg::decision_e decision_i,
  input  logic [`RAB_PADDR_W-1:0]   out_addr_i,
  input  logic                      coherent_i,
  input  logic                      p1_sent_i,
  input  logic                      p2_sent_i,
  output logic                      p1_accept_o,
  output logic                      p1_drop_o,
  output logic                      p2_accept_o,
  output logic                      p2_drop_o,
  output logic                      grant_p1_o,
  output logic                      grant_p2_o,
  output logic [`RAB_PADDR_W-1:0]   out_addr_o,
  output logic                      coherent_o,
  output logic                      miss_o,
  output logic                      prot_o,
  output logic                      multi_o,
  output logic [`RAB_VADDR_W-1:0]   miss_addr_o
);

  rab_lookup_pkg::lookup_state_e state_q;
  rab_lookup_pkg::lookup_state_e state_d;
  rab_lookup_pkg::decision_e     dec_q;
  logic                          port_p1_q;
  logic                          capture;
  logic                          deciding;
  logic                          accepted;
  logic                          sent_sel;

  assign capture  = (state_q == rab_lookup_pkg::ST_IDLE) && any_valid_i;
  assign deciding = (state_q == rab_lookup_pkg::ST_DECIDE);
  assign accepted = (dec_q == rab_lookup_pkg::DEC_ACCEPT);
  // only the granted channel's sent ends the wait
  assign sent_sel = port_p1_q ? p1_sent_i : p2_sent_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rab_lookup_pkg::ST_IDLE: begin
        if (any_valid_i) begin
          state_d = rab_lookup_pkg::ST_DECIDE;
        end
      end
      rab_lookup_pkg::ST_DECIDE: begin
        // sent may already come with the accept
        if (!accepted || sent_sel) begin
          state_d = rab_lookup_pkg::ST_IDLE;
        end else begin
          state_d = rab_lookup_pkg::ST_WAIT_SENT;
        end
      end
      rab_lookup_pkg::ST_WAIT_SENT: begin
        if (sent_sel) begin
          state_d = rab_lookup_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = rab_lookup_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q     <= rab_lookup_pkg::ST_IDLE;
      dec_q       <= rab_lookup_pkg::DEC_MISS;
      port_p1_q   <= 1'b1;
      out_addr_o  <= '0;
      coherent_o  <= 1'b0;
      miss_addr_o <= '0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        dec_q      <= decision_i;
        port_p1_q  <= sel_port_i;
        out_addr_o <= out_addr_i;
        coherent_o <= coherent_i;
        // miss address is kept until the next miss
        if (decision_i == rab_lookup_pkg::DEC_MISS) begin
          miss_addr_o <= sel_addr_min_i;
        end
      end
    end
  end

  // one-cycle pulses in ST_DECIDE, decoded from the captured decision
  assign p1_accept_o = deciding && port_p1_q && accepted;
  assign p1_drop_o   = deciding && port_p1_q && !accepted;
  assign p2_accept_o = deciding && !port_p1_q && accepted;
  assign p2_drop_o   = deciding && !port_p1_q && !accepted;

  assign grant_p1_o = deciding && port_p1_q;
  assign grant_p2_o = deciding && !port_p1_q;

  assign miss_o  = deciding && (dec_q == rab_lookup_pkg::DEC_MISS);
  assign prot_o  = deciding && (dec_q == rab_lookup_pkg::DEC_PROT);
  assign multi_o = deciding && (dec_q == rab_lookup_pkg::DEC_MULTI);

endmodule

//--- rab_core.sv
// rab_core: one remapping lane built from config bank, arbiter, slice compare and lookup FSM
`timescale 1ns/1ps
`include "rab_defs.svh"

module rab_core (
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  logic                       cfg_we_i,
  input  logic [`RAB_CFG_IDX_W-1:0]  cfg_idx_i,
  input  logic [`RAB_CFG_DATA_W-1:0] cfg_data_i,
  input  logic [`RAB_VADDR_W-1:0]    p1_addr_i,
  input  logic [`RAB_LEN_W-1:0]      p1_len_i,
  input  logic [`RAB_SIZE_W-1:0]     p1_size_i,
  input  logic                       p1_valid_i,
  input  logic                       p1_sent_i,
  input  logic [`RAB_VADDR_W-1:0]    p2_addr_i,
  input  logic [`RAB_LEN_W-1:0]      p2_len_i,
  input  logic [`RAB_SIZE_W-1:0]     p2_size_i,
  input  logic                       p2_valid_i,
  input  logic                       p2_sent_i,
  output logic                       p1_accept_o,
  output logic                       p1_drop_o,
  output logic                       p2_accept_o,
  output logic                       p2_drop_o,
  output logic [`RAB_PADDR_W-1:0]    out_addr_o,
  output logic                       coherent_o,
  output logic                       miss_o,
  output logic                       prot_o,
  output logic                       multi_o,
  output logic [`RAB_VADDR_W-1:0]    miss_addr_o
);

  localparam int N_SLICES = `RAB_N_SLICES;
  localparam int VADDR_W  = `RAB_VADDR_W;
  localparam int PADDR_W  = `RAB_PADDR_W;

  // slice bank contents
  logic [N_SLICES-1:0][VADDR_W-1:0]     slice_start;
  logic [N_SLICES-1:0][VADDR_W-1:0]     slice_end;
  logic [N_SLICES-1:0][PADDR_W-1:0]     slice_offset;
  rab_cfg_pkg::slice_flags_t [N_SLICES-1:0] slice_flags;

  // selected request
  logic [VADDR_W-1:0] sel_addr_min;
  logic [VADDR_W-1:0] sel_addr_max;
  logic               sel_is_write;
  logic               sel_port;
  logic               any_valid;

  // compare result and grant feedback
  rab_lookup_pkg::decision_e decision;
  logic [PADDR_W-1:0]        match_out_addr;
  logic                      match_coherent;
  logic                      grant_p1;
  logic                      grant_p2;

  rab_cfg_regs rab_cfg_regs_i (
    .Clk_CI         ( Clk_CI       ),
    .Rst_RBI        ( Rst_RBI      ),
    .cfg_we_i       ( cfg_we_i     ),
    .cfg_idx_i      ( cfg_idx_i    ),
    .cfg_data_i     ( cfg_data_i   ),
    .slice_start_o  ( slice_start  ),
    .slice_end_o    ( slice_end    ),
    .slice_offset_o ( slice_offset ),
    .slice_flags_o  ( slice_flags  )
  );

  rab_req_arbiter rab_req_arbiter_i (
    .Clk_CI         ( Clk_CI       ),
    .Rst_RBI        ( Rst_RBI      ),
    .p1_addr_i      ( p1_addr_i    ),
    .p2_addr_i      ( p2_addr_i    ),
    .p1_len_i       ( p1_len_i     ),
    .p2_len_i       ( p2_len_i     ),
    .p1_size_i      ( p1_size_i    ),
    .p2_size_i      ( p2_size_i    ),
    .p1_valid_i     ( p1_valid_i   ),
    .p2_valid_i     ( p2_valid_i   ),
    .grant_p1_i     ( grant_p1     ),
    .grant_p2_i     ( grant_p2     ),
    .sel_addr_min_o ( sel_addr_min ),
    .sel_addr_max_o ( sel_addr_max ),
    .sel_is_write_o ( sel_is_write ),
    .sel_port_o     ( sel_port     ),
    .any_valid_o    ( any_valid    )
  );

  rab_slice_match rab_slice_match_i (
    .sel_addr_min_i ( sel_addr_min   ),
    .sel_addr_max_i ( sel_addr_max   ),
    .sel_is_write_i ( sel_is_write   ),
    .slice_start_i  ( slice_start    ),
    .slice_end_i    ( slice_end      ),
    .slice_offset_i ( slice_offset   ),
    .slice_flags_i  ( slice_flags    ),
    .decision_o     ( decision       ),
    .out_addr_o     ( match_out_addr ),
    .coherent_o     ( match_coherent )
  );

  rab_lookup_fsm rab_lookup_fsm_i (
    .Clk_CI         ( Clk_CI         ),
    .Rst_RBI        ( Rst_RBI        ),
    .any_valid_i    ( any_valid      ),
    .sel_port_i     ( sel_port       ),
    .sel_addr_min_i ( sel_addr_min   ),
    .decision_i     ( decision       ),
    .out_addr_i     ( match_out_addr ),
    .coherent_i     ( match_coherent ),
    .p1_sent_i      ( p1_sent_i      ),
    .p2_sent_i      ( p2_sent_i      ),
    .p1_accept_o    ( p1_accept_o    ),
    .p1_drop_o      ( p1_drop_o      ),
    .p2_accept_o    ( p2_accept_o    ),
    .p2_drop_o      ( p2_drop_o      ),
    .grant_p1_o     ( grant_p1       ),
    .grant_p2_o     ( grant_p2       ),
    .out_addr_o     ( out_addr_o     ),
    .coherent_o     ( coherent_o     ),
    .miss_o         ( miss_o         ),
    .prot_o         ( prot_o         ),
    .multi_o        ( multi_o        ),
    .miss_addr_o    ( miss_addr_o    )
  );

endmodule

//--- tb_rab_core.sv
// tb_rab_core: table-driven testbench for the remapping lane with slice setup and request checks
`timescale 1ns/1ps
`include "rab_defs.svh"

module tb_rab_core;

  localparam int N_ROWS     = 13;
  localparam int MAX_CYCLES = N_ROWS * 12 + 200;

  // one request row; channel 3 drives both channels with the same burst
  typedef struct packed {
    logic [1:0]                  ch;
    logic [`RAB_VADDR_W-1:0]     addr;
    logic [`RAB_LEN_W-1:0]       len;
    logic [`RAB_SIZE_W-1:0]      size;
    rab_lookup_pkg::decision_e   exp_dec;
    // translated address on accept, request address on miss
    logic [`RAB_PADDR_W-1:0]     exp_addr;
    logic                        exp_coh;
    // optional flags rewrite of one slice before the request
    logic                        pre_we;
    logic [1:0]                  pre_slice;
    logic [3:0]                  pre_flags;
  } req_row_t;

  logic                       Clk_CI;
  logic                       Rst_RBI;
  logic                       cfg_we_i;
  logic [`RAB_CFG_IDX_W-1:0]  cfg_idx_i;
  logic [`RAB_CFG_DATA_W-1:0] cfg_data_i;
  logic [`RAB_VADDR_W-1:0]    p1_addr_i;
  logic [`RAB_LEN_W-1:0]      p1_len_i;
  logic [`RAB_SIZE_W-1:0]     p1_size_i;
  logic                       p1_valid_i;
  logic                       p1_sent_i;
  logic [`RAB_VADDR_W-1:0]    p2_addr_i;
  logic [`RAB_LEN_W-1:0]      p2_len_i;
  logic [`RAB_SIZE_W-1:0]     p2_size_i;
  logic                       p2_valid_i;
  logic                       p2_sent_i;
  logic                       p1_accept_o;
  logic                       p1_drop_o;
  logic                       p2_accept_o;
  logic                       p2_drop_o;
  logic [`RAB_PADDR_W-1:0]    out_addr_o;
  logic                       coherent_o;
  logic                       miss_o;
  logic                       prot_o;
  logic                       multi_o;
  logic [`RAB_VADDR_W-1:0]    miss_addr_o;

  // slice 0 disabled, 1 read-only, 2 coherent, 2 and 3 overlap at 0x8800
  logic [`RAB_VADDR_W-1:0] cfg_start [`RAB_N_SLICES] = '{
    32'h0000_C000, 32'h0000_4000, 32'h0000_8000, 32'h0000_8800};
  logic [`RAB_VADDR_W-1:0] cfg_end [`RAB_N_SLICES] = '{
    32'h0000_CFFF, 32'h0000_4FFF, 32'h0000_8FFF, 32'h0000_9FFF};
  logic [`RAB_PADDR_W-1:0] cfg_offset [`RAB_N_SLICES] = '{
    40'h05_0000_0000, 40'h00_8000_0000, 40'h02_0000_0000, 40'h03_0000_0000};
  // bits are coherent, write_en, read_en, enable
  rab_cfg_pkg::slice_flags_t cfg_flags [`RAB_N_SLICES] = '{
    4'b0110, 4'b0011, 4'b1111, 4'b0111};

  req_row_t req_table [N_ROWS] = '{
    // both channels right after reset
    '{2'd3, 32'h0000_8100, 8'd0, 3'd2, rab_lookup_pkg::DEC_ACCEPT, 40'h02_0000_0100, 1'b1,
      1'b0, 2'd0, 4'h0},
    '{2'd1, 32'h0000_9010, 8'd3, 3'd3, rab_lookup_pkg::DEC_ACCEPT, 40'h03_0000_0810, 1'b0,
      1'b0, 2'd0, 4'h0},
    // unaligned start, burst ends at 0x4125
    '{2'd1, 32'h0000_4123, 8'd1, 3'd1, rab_lookup_pkg::DEC_ACCEPT, 40'h00_8000_0123, 1'b0,
      1'b0, 2'd0, 4'h0},
    '{2'd1, 32'h0000_2000, 8'd0, 3'd0, rab_lookup_pkg::DEC_MISS, 40'h00_0000_2000, 1'b0,
      1'b0, 2'd0, 4'h0},
    // range of the disabled slice
    '{2'd2, 32'h0000_C100, 8'd0, 3'd2, rab_lookup_pkg::DEC_MISS, 40'h00_0000_C100, 1'b0,
      1'b0, 2'd0, 4'h0},
    // ends exactly at 0x4fff
    '{2'd1, 32'h0000_4FF0, 8'd1, 3'd3, rab_lookup_pkg::DEC_ACCEPT, 40'h00_8000_0FF0, 1'b0,
      1'b0, 2'd0, 4'h0},
    // aligned down to 0x4ff0, so the end is 0x4fff again
    '{2'd1, 32'h0000_4FF5, 8'd1, 3'd3, rab_lookup_pkg::DEC_ACCEPT, 40'h00_8000_0FF5, 1'b0,
      1'b0, 2'd0, 4'h0},
    // end 0x5007 runs past the slice
    '{2'd1, 32'h0000_4FF0, 8'd2, 3'd3, rab_lookup_pkg::DEC_MISS, 40'h00_0000_4FF0, 1'b0,
      1'b0, 2'd0, 4'h0},
    '{2'd2, 32'h0000_4200, 8'd0, 3'd2, rab_lookup_pkg::DEC_PROT, 40'h00_0000_0000, 1'b0,
      1'b0, 2'd0, 4'h0},
    '{2'd1, 32'h0000_4200, 8'd0, 3'd2, rab_lookup_pkg::DEC_ACCEPT, 40'h00_8000_0200, 1'b0,
      1'b0, 2'd0, 4'h0},
    '{2'd1, 32'h0000_8900, 8'd0, 3'd2, rab_lookup_pkg::DEC_MULTI, 40'h00_0000_0000, 1'b0,
      1'b0, 2'd0, 4'h0},
    // both channels again, order follows the alternation
    '{2'd3, 32'h0000_9100, 8'd0, 3'd2, rab_lookup_pkg::DEC_ACCEPT, 40'h03_0000_0900, 1'b0,
      1'b0, 2'd0, 4'h0},
    // slice 1 loses its enable, the earlier read now misses
    '{2'd1, 32'h0000_4200, 8'd0, 3'd2, rab_lookup_pkg::DEC_MISS, 40'h00_0000_4200, 1'b0,
      1'b1, 2'd1, 4'b0010}
  };

  int   cycle_cnt = 0;
  int   row_errors;
  int   n_tests;
  int   n_failed;
  // model of the arbiter priority
  logic prio_p1;

  rab_core rab_core_i (.*);

  initial begin
    Clk_CI = 1'b0;
    forever #5 Clk_CI = ~Clk_CI;
  end

  always @(posedge Clk_CI) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [`RAB_CFG_IDX_W-1:0] cfg_index(
    input int                      slice,
    input rab_cfg_pkg::cfg_field_e field
  );
    return `RAB_CFG_IDX_W'(slice * `RAB_REGS_PER_SLICE + int'(field));
  endfunction

  task automatic write_cfg(input logic [`RAB_CFG_IDX_W-1:0] idx,
                           input logic [`RAB_CFG_DATA_W-1:0] data);
    @(posedge Clk_CI);
    cfg_we_i   <= 1'b1;
    cfg_idx_i  <= idx;
    cfg_data_i <= data;
    @(posedge Clk_CI);
    cfg_we_i   <= 1'b0;
  endtask

  task automatic program_slices();
    for (int s = 0; s < `RAB_N_SLICES; s++) begin
      write_cfg(cfg_index(s, rab_cfg_pkg::FIELD_START), 64'(cfg_start[s]));
      write_cfg(cfg_index(s, rab_cfg_pkg::FIELD_END), 64'(cfg_end[s]));
      write_cfg(cfg_index(s, rab_cfg_pkg::FIELD_OFFSET), 64'(cfg_offset[s]));
      write_cfg(cfg_index(s, rab_cfg_pkg::FIELD_FLAGS), 64'(cfg_flags[s]));
    end
  endtask

  task automatic wait_decision();
    do begin
      @(negedge Clk_CI);
    end while (!(p1_accept_o || p1_drop_o || p2_accept_o || p2_drop_o));
  endtask

  task automatic check_no_decision(input int ch);
    assert (!(p1_accept_o || p1_drop_o || p2_accept_o || p2_drop_o || miss_o || prot_o ||
              multi_o))
    else begin
      $display("Error at %0t: decision pulse around the sent of channel %0d", $time, ch);
      row_errors++;
    end
  endtask

  task automatic check_decision(input int ch, input req_row_t row);
    logic acc;
    logic drp;
    logic other;
    logic exp_acc;
    acc     = (ch == 1) ? p1_accept_o : p2_accept_o;
    drp     = (ch == 1) ? p1_drop_o : p2_drop_o;
    other   = (ch == 1) ? (p2_accept_o | p2_drop_o) : (p1_accept_o | p1_drop_o);
    exp_acc = (row.exp_dec == rab_lookup_pkg::DEC_ACCEPT);
    assert (acc == exp_acc && drp == !exp_acc)
    else begin
      $display("Error at %0t: channel %0d accept %b drop %b, expected %s",
               $time, ch, acc, drp, row.exp_dec.name());
      row_errors++;
    end
    assert (!other)
    else begin
      $display("Error at %0t: decision on the wrong channel, expected %0d", $time, ch);
      row_errors++;
    end
    assert (miss_o == (row.exp_dec == rab_lookup_pkg::DEC_MISS) &&
            prot_o == (row.exp_dec == rab_lookup_pkg::DEC_PROT) &&
            multi_o == (row.exp_dec == rab_lookup_pkg::DEC_MULTI))
    else begin
      $display("Error at %0t: miss %b prot %b multi %b, expected %s",
               $time, miss_o, prot_o, multi_o, row.exp_dec.name());
      row_errors++;
    end
    if (exp_acc) begin
      assert (out_addr_o == row.exp_addr && coherent_o == row.exp_coh)
      else begin
        $display("Error at %0t: out_addr %h coherent %b, expected %h and %b",
                 $time, out_addr_o, coherent_o, row.exp_addr, row.exp_coh);
        row_errors++;
      end
    end
    if (row.exp_dec == rab_lookup_pkg::DEC_MISS) begin
      assert (miss_addr_o == row.exp_addr[`RAB_VADDR_W-1:0])
      else begin
        $display("Error at %0t: miss_addr %h, expected %h",
                 $time, miss_addr_o, row.exp_addr[`RAB_VADDR_W-1:0]);
        row_errors++;
      end
    end
  endtask

  // check one decision, release the channel and send after an accept
  task automatic handle_decision(input int ch, input req_row_t row);
    int delay;
    wait_decision();
    check_decision(ch, row);
    prio_p1 = (ch != 1);
    @(posedge Clk_CI);
    if (ch == 1) p1_valid_i <= 1'b0;
    else p2_valid_i <= 1'b0;
    if (row.exp_dec == rab_lookup_pkg::DEC_ACCEPT) begin
      delay = int'($urandom_range(3, 0));
      repeat (delay) begin
        @(negedge Clk_CI);
        check_no_decision(ch);
        @(posedge Clk_CI);
      end
      if (ch == 1) p1_sent_i <= 1'b1;
      else p2_sent_i <= 1'b1;
      @(negedge Clk_CI);
      check_no_decision(ch);
      @(posedge Clk_CI);
      p1_sent_i <= 1'b0;
      p2_sent_i <= 1'b0;
      // back in idle after the sent, a waiting channel is captured one edge later
      @(negedge Clk_CI);
      check_no_decision(ch);
    end
  endtask

  task automatic run_row(input int r);
    req_row_t row;
    int       first_ch;
    row        = req_table[r];
    row_errors = 0;
    if (row.pre_we) begin
      write_cfg(cfg_index(int'(row.pre_slice), rab_cfg_pkg::FIELD_FLAGS), 64'(row.pre_flags));
    end
    @(posedge Clk_CI);
    if (row.ch[0]) begin
      p1_addr_i  <= row.addr;
      p1_len_i   <= row.len;
      p1_size_i  <= row.size;
      p1_valid_i <= 1'b1;
    end
    if (row.ch[1]) begin
      p2_addr_i  <= row.addr;
      p2_len_i   <= row.len;
      p2_size_i  <= row.size;
      p2_valid_i <= 1'b1;
    end
    first_ch = (row.ch == 2'd3) ? (prio_p1 ? 1 : 2) : int'(row.ch);
    handle_decision(first_ch, row);
    if (row.ch == 2'd3) begin
      handle_decision(3 - first_ch, row);
    end
    n_tests++;
    if (row_errors != 0) n_failed++;
    $display("test %0d: channel %0d addr %h %s %s", r, first_ch, row.addr,
             row.exp_dec.name(), (row_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    void'($urandom(53));
    n_tests    = 0;
    n_failed   = 0;
    prio_p1    = 1'b1;
    Rst_RBI    <= 1'b0;
    cfg_we_i   <= 1'b0;
    cfg_idx_i  <= '0;
    cfg_data_i <= '0;
    p1_addr_i  <= '0;
    p1_len_i   <= '0;
    p1_size_i  <= '0;
    p1_valid_i <= 1'b0;
    p1_sent_i  <= 1'b0;
    p2_addr_i  <= '0;
    p2_len_i   <= '0;
    p2_size_i  <= '0;
    p2_valid_i <= 1'b0;
    p2_sent_i  <= 1'b0;
    repeat (10) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;
    program_slices();
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    $display("tests run: %0d, failed: %0d", n_tests, n_failed);
    if (n_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- rab_core.f
+incdir+.
rab_cfg_pkg.sv
rab_lookup_pkg.sv
rab_cfg_regs.sv
rab_req_arbiter.sv
rab_slice_match.sv
rab_lookup_fsm.sv
rab_core.sv
tb_rab_core.sv

//--- Makefile
# Verilator build and run of the remapping lane testbench

VERILATOR ?= verilator
TOP       ?= tb_rab_core
FILELIST  ?= rab_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from the search for the pass line in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
